// File: list.f
source/noc_params.sv
source/circular_buffer.sv
source/flit_ingress.sv
source/vc_arbiter.sv
source/input_port.sv
dv/tb_input_port.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_input_port
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: sim clean

# build, run, and judge the run by the pass line in its output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_input_port.sv
`timescale 1ns/1ps

module tb_input_port;

    import noc_params::*;

    localparam int N_RAND_PKTS = 40;    // packets of the random phase
    localparam int MAX_LEN     = 5;     // longest packet in flits
    localparam int MAX_DELAY   = 3;     // sink ack delay in the random phase
    localparam int BP_VC       = 2;     // channel flooded in the back-pressure phase
    localparam int BP_PKTS     = 3;
    localparam int BP_DELAY    = 40;    // long sink stall per flit
    localparam int HS_CYCLES   = 12;    // worst four-phase round trip without sink delay
    localparam int TOTAL_FLITS = N_RAND_PKTS * MAX_LEN + BP_PKTS * MAX_LEN;
    // each flit costs at most one full output handshake plus the worst stall
    localparam int TIMEOUT_CYCLES = TOTAL_FLITS * (HS_CYCLES + BP_DELAY) + 500;

    logic  clk;
    logic  rst;
    flit_t in_flit_i;
    logic  in_req_i;
    logic  in_ack_o;
    flit_t out_flit_o;
    logic  out_req_o;
    logic  out_ack_i;

    int    seed = 69379;
    int    ack_delay;                 // cycles the sink waits before acking
    int    pkt_cnt [NUM_VC];          // packets sent so far per channel
    int    tx_count;                  // flits offered on the input
    int    max_in_wait;               // longest input ack wait, in cycles
    int    cycle_count;
    logic  ack_at_edge;               // out_ack_i as the DUT saw it at the last rising edge
    flit_t exp_q [NUM_VC][$];         // expected output order per channel

    input_port u_input_port (
        .clk        (clk),
        .rst        (rst),
        .in_flit_i  (in_flit_i),
        .in_req_i   (in_req_i),
        .out_ack_i  (out_ack_i),
        .in_ack_o   (in_ack_o),
        .out_flit_o (out_flit_o),
        .out_req_o  (out_req_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want)
        begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, want);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int unsigned r;
        r = $unsigned($random(seed));
        return lo + int'(r % $unsigned(hi - lo + 1));
    endfunction

    // reference model of a flit: label from its position, payload from
    // channel, packet number on that channel and flit index
    function automatic flit_t expected_flit(input int vc, input int pkt, input int idx,
                                            input int len);
        flit_t f;
        f.vc_id = VC_ID_WIDTH'(vc);
        if (len == 1)
            f.label = HEADTAIL;
        else if (idx == 0)
            f.label = HEAD;
        else if (idx == len - 1)
            f.label = TAIL;
        else
            f.label = BODY;
        f.data = DATA_WIDTH'({4'(vc), 20'(pkt), 8'(idx)} ^ 32'h3C5A_0F00);
        return f;
    endfunction

    function automatic bit queues_empty();
        for (int v = 0; v < NUM_VC; v++)
            if (exp_q[v].size() != 0)
                return 1'b0;
        return 1'b1;
    endfunction

    // one four-phase transfer on the input link, entered and left on a falling edge
    task automatic send_flit(input flit_t f);
        int wait_cycles;
        wait_cycles = 0;
        in_flit_i   = f;
        in_req_i    = 1'b1;
        @(negedge clk);
        while (!in_ack_o)
        begin
            @(negedge clk);
            wait_cycles++;   // buffer full, ack held back
        end
        if (wait_cycles > max_in_wait)
            max_in_wait = wait_cycles;
        in_req_i = 1'b0;
        @(negedge clk);
        while (in_ack_o)
            @(negedge clk);
    endtask

    task automatic send_packet(input int vc, input int len);
        flit_t f;
        for (int idx = 0; idx < len; idx++)
        begin
            f = expected_flit(vc, pkt_cnt[vc], idx, len);
            exp_q[vc].push_back(f);   // queued before req so the monitor never races it
            tx_count++;
            send_flit(f);
        end
        pkt_cnt[vc]++;
    endtask

    // stimulus
    initial
    begin
        int vc;
        int len;
        rst         = 1'b1;
        in_req_i    = 1'b0;
        in_flit_i   = '0;
        ack_delay   = 0;
        tx_count    = 0;
        max_in_wait = 0;
        for (int v = 0; v < NUM_VC; v++)
            pkt_cnt[v] = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        check_value("in_ack_o", 64'(in_ack_o), 64'(0));
        check_value("out_req_o", 64'(out_req_o), 64'(0));
        repeat (5)
        begin
            @(negedge clk);
            check_value("out_req_o", 64'(out_req_o), 64'(0));   // idle with nothing sent
        end

        for (int p = 0; p < N_RAND_PKTS; p++)
        begin
            vc        = rand_range(0, NUM_VC - 1);
            len       = rand_range(1, MAX_LEN);
            ack_delay = rand_range(0, MAX_DELAY);
            send_packet(vc, len);
        end

        // flood one channel past its depth while the sink crawls
        ack_delay   = BP_DELAY;
        max_in_wait = 0;
        for (int p = 0; p < BP_PKTS; p++)
            send_packet(BP_VC, MAX_LEN);
        ack_delay = 0;   // sink resumes
        if (max_in_wait < BP_DELAY / 2)
            abort_run("input ack was never held back while the channel buffer was full");

        while (!queues_empty() || out_req_o || out_ack_i)
            @(negedge clk);
        repeat (5) @(negedge clk);   // a stray extra flit would still show up here

        $display("Simulation PASSED");
        $finish;
    end

    // sink, acks each request after the current delay
    initial
    begin
        out_ack_i = 1'b0;
        forever
        begin
            @(negedge clk);
            if (out_req_o)
            begin
                repeat (ack_delay) @(negedge clk);
                out_ack_i = 1'b1;
                @(negedge clk);
                while (out_req_o)
                    @(negedge clk);
                out_ack_i = 1'b0;
            end
        end
    end

    always @(posedge clk)
        ack_at_edge <= out_ack_i;

    // monitor and compare on the output link
    initial
    begin
        flit_t                  held;
        flit_t                  want;
        logic                   req_prev;
        logic                   in_pkt;     // between head and tail
        logic [VC_ID_WIDTH-1:0] pkt_vc;
        int                     vc;
        req_prev = 1'b0;
        in_pkt   = 1'b0;
        pkt_vc   = '0;
        forever
        begin
            @(negedge clk);
            if (out_req_o && !req_prev)
            begin
                check_value("out_ack_i", 64'(ack_at_edge), 64'(0));   // ack low when req rose
                if (tx_count == 0)
                    abort_run("output request raised before any flit was sent in");
                held = out_flit_o;
                vc   = int'(held.vc_id);
                if (exp_q[vc].size() == 0)
                    abort_run("output flit on a channel with nothing outstanding");
                want = exp_q[vc].pop_front();
                check_value("out_flit_o.label", 64'(held.label), 64'(want.label));
                check_value("out_flit_o.vc_id", 64'(held.vc_id), 64'(want.vc_id));
                check_value("out_flit_o.data", 64'(held.data), 64'(want.data));
                if (in_pkt)
                    check_value("out_flit_o.vc_id", 64'(held.vc_id), 64'(pkt_vc));   // no interleave
                if (held.label == HEAD)
                begin
                    in_pkt = 1'b1;
                    pkt_vc = held.vc_id;
                end
                else if (held.label == TAIL)
                    in_pkt = 1'b0;
            end
            else if (out_req_o)
                check_value("out_flit_o", 64'(out_flit_o), 64'(held));   // stable while req high
            req_prev = out_req_o;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("timeout after %0d cycles, output never drained", cycle_count));
    end

    initial
        cycle_count = 0;

endmodule

// File: source/input_port.sv
`timescale 1ns/1ps

module input_port (
    input  logic              clk,
    input  logic              rst,
    input  noc_params::flit_t in_flit_i,
    input  logic              in_req_i,
    input  logic              out_ack_i,
    output logic              in_ack_o,
    output noc_params::flit_t out_flit_o,
    output logic              out_req_o
);

    import noc_params::*;

    flit_t             rx_flit;                // flit from the link, shared by all buffers
    logic [NUM_VC-1:0] vc_write;               // one-hot push strobe
    logic [NUM_VC-1:0] vc_read;                // one-hot pop strobe
    logic [NUM_VC-1:0] full;
    logic [NUM_VC-1:0] empty;
    flit_t             head_flits [NUM_VC];    // oldest flit of each channel

    flit_ingress u_flit_ingress (
        .clk       (clk),
        .rst       (rst),
        .in_flit_i (in_flit_i),
        .in_req_i  (in_req_i),
        .full_i    (full),
        .in_ack_o  (in_ack_o),
        .flit_o    (rx_flit),
        .write_o   (vc_write)
    );

    // one FIFO per virtual channel
    for (genvar v = 0; v < NUM_VC; v++)
    begin : g_vc
        circular_buffer #(
            .BUFFER_SIZE (VC_SIZE)
        ) u_circular_buffer (
            .clk        (clk),
            .rst        (rst),
            .data_i     (rx_flit),
            .read_i     (vc_read[v]),
            .write_i    (vc_write[v]),
            .data_o     (head_flits[v]),
            .is_full_o  (full[v]),
            .is_empty_o (empty[v])
        );
    end

    vc_arbiter u_vc_arbiter (
        .clk          (clk),
        .rst          (rst),
        .head_flits_i (head_flits),
        .empty_i      (empty),
        .out_ack_i    (out_ack_i),
        .read_o       (vc_read),
        .out_flit_o   (out_flit_o),
        .out_req_o    (out_req_o)
    );

endmodule

// File: source/vc_arbiter.sv
`timescale 1ns/1ps

module vc_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  noc_params::flit_t             head_flits_i [noc_params::NUM_VC],
    input  logic [noc_params::NUM_VC-1:0] empty_i,
    input  logic                          out_ack_i,
    output logic [noc_params::NUM_VC-1:0] read_o,
    output noc_params::flit_t             out_flit_o,
    output logic                          out_req_o
);

    import noc_params::*;

    tx_state_t              state;
    tx_state_t              state_next;
    logic [VC_ID_WIDTH-1:0] rr_ptr;     // channel of the last popped flit
    logic                   locked;     // a packet is in flight
    logic [VC_ID_WIDTH-1:0] lock_vc;    // channel owning the output
    logic [VC_ID_WIDTH-1:0] sel_vc;     // channel picked this cycle
    logic [VC_ID_WIDTH-1:0] cand_vc;    // round-robin candidate
    logic                   found;      // sel_vc has a flit ready
    logic                   pop;        // flit leaves its buffer at this edge
    flit_t                  sel_flit;   // head flit of sel_vc

    // channel choice: the locked one, else first non-empty after rr_ptr
    always_comb
    begin
        found   = 1'b0;
        sel_vc  = lock_vc;
        cand_vc = rr_ptr;
        if (locked)
            found = !empty_i[lock_vc];   // wormhole, wait for the rest of the packet
        else
        begin
            for (int i = 1; i <= NUM_VC; i++)
            begin
                cand_vc = VC_ID_WIDTH'((int'(rr_ptr) + i) % NUM_VC);
                if (!found && !empty_i[cand_vc])
                begin
                    found  = 1'b1;
                    sel_vc = cand_vc;
                end
            end
        end
    end

    assign sel_flit = head_flits_i[sel_vc];
    assign pop      = (state == TX_IDLE) && found;

    always_comb
    begin
        read_o = '0;
        if (pop)
            read_o[sel_vc] = 1'b1;   // one pulse per flit sent
    end

    always_comb
    begin
        state_next = state;
        unique case (state)
            TX_IDLE:
            begin
                if (found)
                    state_next = TX_REQ;            // flit loaded, raise req
            end
            TX_REQ:
            begin
                if (out_ack_i)
                    state_next = TX_WAIT_ACK_LOW;   // sink took it, drop req
            end
            TX_WAIT_ACK_LOW:
            begin
                if (!out_ack_i)
                    state_next = TX_IDLE;           // handshake closed
            end
            default:
                state_next = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= TX_IDLE;
            rr_ptr  <= '0;
            locked  <= 1'b0;
            lock_vc <= '0;
        end
        else
        begin
            state <= state_next;
            if (pop)
            begin
                rr_ptr <= sel_vc;
                unique case (sel_flit.label)
                    HEAD:
                    begin
                        locked  <= 1'b1;
                        lock_vc <= sel_vc;
                    end
                    TAIL, HEADTAIL:
                        locked <= 1'b0;
                    default:
                        locked <= locked;   // body keeps the current owner
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
            out_flit_o <= sel_flit;   // held until the next pop
    end

    assign out_req_o = (state == TX_REQ);

    // four-phase rule on the output, the sink only acks a pending req
    assert property (@(posedge clk) disable iff (rst) $rose(out_ack_i) |-> out_req_o)
        else $error("vc_arbiter: out_ack_i rose without a pending out_req_o");

endmodule

// File: source/flit_ingress.sv
`timescale 1ns/1ps

module flit_ingress (
    input  logic                          clk,
    input  logic                          rst,
    input  noc_params::flit_t             in_flit_i,
    input  logic                          in_req_i,
    input  logic [noc_params::NUM_VC-1:0] full_i,
    output logic                          in_ack_o,
    output noc_params::flit_t             flit_o,
    output logic [noc_params::NUM_VC-1:0] write_o
);

    import noc_params::*;

    rx_state_t         state;
    rx_state_t         state_next;
    logic [NUM_VC-1:0] vc_sel;   // one-hot decode of the incoming vc_id
    logic              accept;   // flit taken at this edge

    // channel decode of the flit on the link
    always_comb
    begin
        vc_sel                  = '0;
        vc_sel[in_flit_i.vc_id] = 1'b1;
    end

    // a new req is only taken when its target buffer has room,
    // otherwise ack is held back until the arbiter frees a slot
    assign accept = (state == RX_IDLE) && in_req_i && !full_i[in_flit_i.vc_id];

    assign write_o = accept ? vc_sel : '0;   // single-cycle strobe into one buffer
    assign flit_o  = in_flit_i;              // sender holds the flit stable while req is high

    always_comb
    begin
        state_next = state;
        unique case (state)
            RX_IDLE:
            begin
                if (accept)
                    state_next = RX_WAIT_REQ_LOW;   // flit written, raise ack
            end
            RX_WAIT_REQ_LOW:
            begin
                if (!in_req_i)
                    state_next = RX_IDLE;           // sender done, drop ack
            end
            default:
                state_next = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state <= RX_IDLE;
        else
            state <= state_next;
    end

    // ack is a decode of the state flop, high from the edge after the write
    assign in_ack_o = (state == RX_WAIT_REQ_LOW);

endmodule

// File: source/circular_buffer.sv
`timescale 1ns/1ps

module circular_buffer #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  noc_params::flit_t data_i,
    input  logic              read_i,
    input  logic              write_i,
    output noc_params::flit_t data_o,
    output logic              is_full_o,
    output logic              is_empty_o
);

    import noc_params::*;

    // pointer type, at least one bit wide so a depth of one still works
    typedef logic [$clog2(BUFFER_SIZE > 1 ? BUFFER_SIZE : 2)-1:0] ptr_t;

    flit_t memory [BUFFER_SIZE];   // ring storage

    ptr_t read_ptr;                // oldest entry
    ptr_t write_ptr;               // next free slot
    ptr_t read_ptr_next;
    ptr_t write_ptr_next;
    logic is_full_next;
    logic is_empty_next;
    logic do_read;                 // accepted pop
    logic do_write;                // accepted push

    // advance a pointer with wrap at the buffer depth
    function automatic ptr_t increase_ptr(input ptr_t ptr);
        if (ptr == ptr_t'(BUFFER_SIZE - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    always_comb
    begin
        do_read  = read_i & ~is_empty_o;
        do_write = write_i & (~is_full_o | do_read);   // a pop in the same cycle frees a slot

        read_ptr_next  = do_read  ? increase_ptr(read_ptr)  : read_ptr;
        write_ptr_next = do_write ? increase_ptr(write_ptr) : write_ptr;

        // push and pop together leave the fill level unchanged
        is_full_next  = is_full_o;
        is_empty_next = is_empty_o;
        if (do_read && !do_write)
        begin
            is_full_next  = 1'b0;
            is_empty_next = (read_ptr_next == write_ptr);   // caught up with writer
        end
        else if (do_write && !do_read)
        begin
            is_empty_next = 1'b0;
            is_full_next  = (write_ptr_next == read_ptr);   // writer wrapped onto reader
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            read_ptr   <= '0;
            write_ptr  <= '0;
            is_full_o  <= 1'b0;
            is_empty_o <= 1'b1;
        end
        else
        begin
            read_ptr   <= read_ptr_next;
            write_ptr  <= write_ptr_next;
            is_full_o  <= is_full_next;
            is_empty_o <= is_empty_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_write)
            memory[write_ptr] <= data_i;
    end

    assign data_o = memory[read_ptr];   // head entry, shown without a clock

    // the ingress must honour the full flag unless a pop makes room
    assert property (@(posedge clk) disable iff (rst) write_i |-> (!is_full_o || read_i))
        else $error("circular_buffer: write into a full buffer");

    // the arbiter must only pop a channel it saw as non-empty
    assert property (@(posedge clk) disable iff (rst) read_i |-> !is_empty_o)
        else $error("circular_buffer: read from an empty buffer");

endmodule

// File: source/noc_params.sv
package noc_params;

    // payload and channel geometry of the port
    localparam int DATA_WIDTH  = 32;               // payload bits per flit
    localparam int NUM_VC      = 4;                // virtual channels per input port
    localparam int VC_SIZE     = 8;                // flits held by each channel buffer
    localparam int VC_ID_WIDTH = $clog2(NUM_VC);   // bits of a channel index

    // position of a flit inside its packet
    typedef enum logic [1:0] {
        HEAD,       // opens a packet, locks the output channel
        BODY,       // middle of a packet
        TAIL,       // closes a packet, frees the output channel
        HEADTAIL    // single-flit packet, never locks
    } flit_label_t;

    // one flit as it travels over a link and through a buffer
    // label sits in the top bits, payload in the low bits
    typedef struct packed {
        flit_label_t            label;   // head/body/tail marker
        logic [VC_ID_WIDTH-1:0] vc_id;   // target virtual channel
        logic [DATA_WIDTH-1:0]  data;    // payload
    } flit_t;

    // receiving side of the four-phase input link
    typedef enum logic {
        RX_IDLE,            // waiting for req, ack low
        RX_WAIT_REQ_LOW     // flit taken, ack high until req drops
    } rx_state_t;

    // sending side of the four-phase output link
    typedef enum logic [1:0] {
        TX_IDLE,            // nothing on the link, ready to pop
        TX_REQ,             // flit on the link, req high until ack
        TX_WAIT_ACK_LOW     // req dropped, sink still holds ack
    } tx_state_t;

endpackage
